// ==== source/demodPkg.sv ====
`default_nettype none

package demodPkg;

    // I and Q width at the demodulator input
    localparam int sampleWidth = 18;

    typedef logic signed [sampleWidth-1:0] sampleT;

    // One complex sample as stored in the frame store
    typedef struct packed {
        sampleT re;     // Real part in the upper half
        sampleT im;
    } iqWordT;

    // Signed timing offset from the trellis, added to the read address
    typedef logic signed [3:0] offsetT;

endpackage

`default_nettype wire

// ==== source/framePkg.sv ====
`default_nettype none

package framePkg;

    // Frame store depth is 2**addrWidth samples
    localparam int addrWidth = 15;

    // Reads stay this many samples behind the write pointer
    localparam int readMargin = 5;

    // Trellis step pacing in clocks
    localparam int clksFast = 2;
    localparam int clksSlow = 4;

    // Interpolate flag on every pairsPerInterp-th pair
    localparam int pairsPerInterp = 4;

endpackage

`default_nettype wire

// ==== source/sampleIngress.sv ====
`default_nettype none

module sampleIngress (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            inReq,
    input  logic                            inSof,
    input  demodPkg::sampleT                inReal,
    input  demodPkg::sampleT                inImag,
    output logic                            inAck,
    output logic                            wrEn,
    output logic [framePkg::addrWidth-1:0]  wrAddr,
    output demodPkg::iqWordT                wrData,
    output logic                            frameStart
);

    logic take;    // New request seen while not yet acked

    assign take = inReq && !inAck;

    // Receive side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            inAck <= 1'b0;
        end else if (take) begin
            inAck <= 1'b1;      // Ack on the edge after the sample is taken
        end else if (!inReq) begin
            inAck <= 1'b0;      // Release once the source drops its request
        end
    end

    // Write strobe, address counter and frame flag
    always_ff @(posedge clk) begin
        if (reset) begin
            wrEn       <= 1'b0;
            wrAddr     <= '0;
            frameStart <= 1'b0;
        end else begin
            wrEn       <= take;             // Single pulse that rises with inAck
            frameStart <= take && inSof;
            if (take) begin
                if (inSof) begin
                    wrAddr <= '0;           // Every frame is stored from address zero
                end else begin
                    wrAddr <= wrAddr + 1'b1;
                end
            end
        end
    end

    // Packed I/Q word, real on top
    always_ff @(posedge clk) begin
        if (take) begin
            wrData <= '{re: inReal, im: inImag};
        end
    end

endmodule

`default_nettype wire

// ==== source/frameStore.sv ====
`default_nettype none

module frameStore (
    input  logic                            clk,
    input  logic                            wrEn,
    input  logic [framePkg::addrWidth-1:0]  wrAddr,
    input  demodPkg::iqWordT                wrData,
    input  logic [framePkg::addrWidth-1:0]  rdAddrA,
    input  logic [framePkg::addrWidth-1:0]  rdAddrB,
    output demodPkg::iqWordT                rdDataA,
    output demodPkg::iqWordT                rdDataB
);

    import demodPkg::*;
    import framePkg::*;

    localparam int storeWords = 2 ** addrWidth;   // Room for a whole frame

    iqWordT mem [storeWords];

    // Single write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Read port A, one clock of latency
    always_ff @(posedge clk) begin
        rdDataA <= mem[rdAddrA];
    end

    // Read port B, independent of A
    always_ff @(posedge clk) begin
        rdDataB <= mem[rdAddrB];
    end

endmodule

`default_nettype wire

// ==== source/trellisFeeder.sv ====
`default_nettype none

module trellisFeeder #(
    parameter int pilotLen      = 512,
    parameter int preload       = 12,
    parameter int pairsPerFrame = 12824,
    parameter int initWait      = 128
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            frameStart,
    input  logic [framePkg::addrWidth-1:0]  wrAddr,
    input  logic                            estimatesDone,
    input  logic                            twoClksPerTrellis,
    input  demodPkg::offsetT                mNdx0,
    input  demodPkg::offsetT                mNdx1,
    input  demodPkg::iqWordT                rdDataA,
    input  demodPkg::iqWordT                rdDataB,
    input  logic                            outAck,
    output logic [framePkg::addrWidth-1:0]  rdAddrA,
    output logic [framePkg::addrWidth-1:0]  rdAddrB,
    output logic                            startOfTrellis,
    output logic                            outReq,
    output demodPkg::sampleT                doutReal0,
    output demodPkg::sampleT                doutImag0,
    output demodPkg::sampleT                doutReal1,
    output demodPkg::sampleT                doutImag1,
    output logic                            interpolate
);

    import demodPkg::*;
    import framePkg::*;

    localparam int waitWidth   = $clog2(initWait + 2);
    localparam int pairWidth   = $clog2(pairsPerFrame + 1);
    localparam int paceWidth   = $clog2(clksSlow);
    localparam int interpWidth = $clog2(pairsPerInterp);
    localparam int offWidth    = $bits(offsetT);
    localparam int extWidth    = addrWidth - offWidth;

    logic                   frameFound;     // Frame in store and trellis not yet started
    logic                   newFrame;       // Next frame arrived since trellis start
    logic                   active;         // Replay of the current frame in progress
    logic [waitWidth-1:0]   waitCnt;
    logic [addrWidth-1:0]   baseAddr;
    logic [addrWidth-1:0]   depth;
    logic [paceWidth-1:0]   paceCnt;
    logic [pairWidth-1:0]   pairCnt;
    logic [interpWidth-1:0] interpCnt;
    logic                   readPending;    // Store output valid this cycle
    logic                   interpPending;
    logic                   depthOk;
    logic                   idle;
    logic                   rdEn;
    iqWordT                 pairA;
    iqWordT                 pairB;

    // Frame detection and trellis start pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            frameFound     <= 1'b0;
            startOfTrellis <= 1'b0;
        end else begin
            startOfTrellis <= estimatesDone && frameFound;
            frameFound     <= frameStart || (frameFound && !estimatesDone);
        end
    end

    // A newer frame restarts wrAddr, so the tail is read without the guard
    always_ff @(posedge clk) begin
        if (reset) begin
            newFrame <= 1'b0;
        end else if (startOfTrellis) begin
            newFrame <= 1'b0;
        end else if (frameStart) begin
            newFrame <= 1'b1;
        end
    end

    assign depth   = wrAddr - baseAddr;
    assign depthOk = (depth > addrWidth'(readMargin)) || newFrame;
    assign idle    = !outReq && !outAck && !readPending;   // Nothing in flight
    assign rdEn    = active && (waitCnt == '0) && (paceCnt == '0) && depthOk && idle;

    // Offsets sign-extended and the sum wrapped to the store size
    assign rdAddrA = baseAddr + {{extWidth{mNdx0[offWidth-1]}}, mNdx0};
    assign rdAddrB = baseAddr + {{extWidth{mNdx1[offWidth-1]}}, mNdx1};

    // Initial wait, pacing and pair counting
    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            waitCnt   <= '0;
            baseAddr  <= '0;
            paceCnt   <= '0;
            pairCnt   <= '0;
            interpCnt <= '0;
        end else if (startOfTrellis) begin
            active    <= 1'b1;
            waitCnt   <= waitWidth'(initWait);
            baseAddr  <= addrWidth'(pilotLen - preload);   // Just before end of pilot
            paceCnt   <= '0;
            pairCnt   <= '0;
            interpCnt <= '0;
        end else begin
            if (waitCnt != '0) begin
                waitCnt <= waitCnt - 1'b1;
            end
            if (rdEn) begin
                baseAddr <= baseAddr + 1'b1;
                paceCnt  <= twoClksPerTrellis ? paceWidth'(clksFast - 1)
                                              : paceWidth'(clksSlow - 1);
                pairCnt  <= pairCnt + 1'b1;
                if (interpCnt == interpWidth'(pairsPerInterp - 1)) begin
                    interpCnt <= '0;
                end else begin
                    interpCnt <= interpCnt + 1'b1;
                end
                if (pairCnt == pairWidth'(pairsPerFrame - 1)) begin
                    active <= 1'b0;     // Last pair of the frame issued
                end
            end else if (paceCnt != '0) begin
                paceCnt <= paceCnt - 1'b1;
            end
        end
    end

    // Send side of the output handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            readPending   <= 1'b0;
            interpPending <= 1'b0;
            outReq        <= 1'b0;
            interpolate   <= 1'b0;
        end else begin
            readPending <= rdEn;
            if (rdEn) begin
                interpPending <= (interpCnt == interpWidth'(pairsPerInterp - 1));
            end
            if (readPending) begin
                outReq      <= 1'b1;            // Two clocks after the read
                interpolate <= interpPending;
            end else if (outReq && outAck) begin
                outReq <= 1'b0;
            end
        end
    end

    // Pair held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (readPending) begin
            pairA <= rdDataA;
            pairB <= rdDataB;
        end
    end

    assign doutReal0 = pairA.re;
    assign doutImag0 = pairA.im;
    assign doutReal1 = pairB.re;
    assign doutImag1 = pairB.im;

endmodule

`default_nettype wire

// ==== source/frameAligner.sv ====
`default_nettype none

module frameAligner #(
    parameter int pilotLen      = 512,
    parameter int preload       = 12,
    parameter int pairsPerFrame = 12824,
    parameter int initWait      = 128
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                inReq,
    output logic                inAck,
    input  demodPkg::sampleT    inReal,
    input  demodPkg::sampleT    inImag,
    input  logic                inSof,
    input  logic                estimatesDone,
    input  logic                twoClksPerTrellis,
    input  demodPkg::offsetT    mNdx0,
    input  demodPkg::offsetT    mNdx1,
    output logic                outReq,
    input  logic                outAck,
    output demodPkg::sampleT    doutReal0,
    output demodPkg::sampleT    doutImag0,
    output demodPkg::sampleT    doutReal1,
    output demodPkg::sampleT    doutImag1,
    output logic                interpolate,
    output logic                startOfTrellis
);

    import demodPkg::*;
    import framePkg::*;

    logic                   wrEn;
    logic [addrWidth-1:0]   wrAddr;     // Also feeds the depth guard
    iqWordT                 wrData;
    logic                   frameStart;
    logic [addrWidth-1:0]   rdAddrA;
    logic [addrWidth-1:0]   rdAddrB;
    iqWordT                 rdDataA;
    iqWordT                 rdDataB;

    sampleIngress sampleIngress_inst (
        .clk, .reset, .inReq, .inSof, .inReal, .inImag,
        .inAck, .wrEn, .wrAddr, .wrData, .frameStart
    );

    frameStore frameStore_inst (
        .clk, .wrEn, .wrAddr, .wrData, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB
    );

    trellisFeeder #(
        .pilotLen      (pilotLen),
        .preload       (preload),
        .pairsPerFrame (pairsPerFrame),
        .initWait      (initWait)
    ) trellisFeeder_inst (
        .clk, .reset, .frameStart, .wrAddr, .estimatesDone, .twoClksPerTrellis,
        .mNdx0, .mNdx1, .rdDataA, .rdDataB, .outAck,
        .rdAddrA, .rdAddrB, .startOfTrellis, .outReq,
        .doutReal0, .doutImag0, .doutReal1, .doutImag1, .interpolate
    );

endmodule

`default_nettype wire

// ==== tests/clockGen.sv ====
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    // Period of 8 time units
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);      // Two cycles of reset
        #1 reset = 1'b0;                // Released with the other inputs
    end

endmodule

`default_nettype wire

// ==== tests/frameAlignerTb.sv ====
`default_nettype none

module frameAlignerTb;

    import demodPkg::*;

    localparam int pilotLen = 24;
    localparam int preload = 12;
    localparam int pairsPerFrame = 40;
    localparam int initWait = 16;
    localparam int samplesPerFrame = 72;
    localparam int estAfter = 30;       // Samples before channel estimation is done
    localparam int numFrames = 3;
    localparam int baseIdx = pilotLen - preload;

    logic clk, reset;
    logic inReq, inAck, inSof, estimatesDone, twoClksPerTrellis;
    sampleT inReal, inImag;
    offsetT mNdx0, mNdx1;
    logic outReq, outAck, interpolate, startOfTrellis;
    sampleT doutReal0, doutImag0, doutReal1, doutImag1;

    sampleT modelRe [samplesPerFrame];  // Samples of the current frame by position
    sampleT modelIm [samplesPerFrame];
    int sent = 0;
    int ackCount = 0;
    int sotCount = 0;
    logic prevAck = 1'b0;

    clockGen clockGen_inst (.clk, .reset);

    frameAligner #(
        .pilotLen      (pilotLen),
        .preload       (preload),
        .pairsPerFrame (pairsPerFrame),
        .initWait      (initWait)
    ) frameAligner_inst (.*);

    task automatic tick;
        @(posedge clk);
        #1;                             // Drive and sample away from the edge
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [35:0] got,
                              input logic [35:0] exp);
        if (got !== exp) begin
            failRun($sformatf("Error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Counts ack rises and trellis start pulses
    initial begin
        forever begin
            tick;
            if (inAck && !prevAck) ackCount++;
            if (startOfTrellis) sotCount++;
            prevAck = inAck;
        end
    end

    // One sample over the four-phase input handshake
    task automatic sendSample(input logic sof, input int idx, input int gap);
        int t;
        repeat (gap) tick;
        modelRe[idx] = sampleT'($urandom);
        modelIm[idx] = sampleT'($urandom);
        checkValue("inAck", inAck, 1'b0);   // Previous cycle fully closed
        inReal = modelRe[idx];
        inImag = modelIm[idx];
        inSof = sof;
        inReq = 1'b1;
        t = 0;
        while (!inAck) begin
            tick;
            t++;
            if (t > 20) failRun("No inAck arrived for an input request");
        end
        inReq = 1'b0;
        inSof = 1'b0;
        t = 0;
        while (inAck) begin
            tick;
            t++;
            if (t > 20) failRun("inAck stayed high after inReq was dropped");
        end
        sent++;
    endtask

    task automatic produceFrame(input int f, input logic slow);
        for (int i = 0; i < samplesPerFrame; i++) begin
            // Slow frame runs below the read rate
            sendSample(i == 0, i, slow ? 8 + int'($urandom % 8) : int'($urandom % 3));
            if (i == estAfter - 1) begin
                checkValue("startOfTrellis count", sotCount, f);    // None before estimates
                estimatesDone = 1'b1;
                tick;
                estimatesDone = 1'b0;
            end
        end
    endtask

    task automatic checkPair(input int k);
        int idx0, idx1;
        idx0 = baseIdx + k + int'(mNdx0);
        idx1 = baseIdx + k + int'(mNdx1);
        checkValue("doutReal0", doutReal0, modelRe[idx0]);
        checkValue("doutImag0", doutImag0, modelIm[idx0]);
        checkValue("doutReal1", doutReal1, modelRe[idx1]);
        checkValue("doutImag1", doutImag1, modelIm[idx1]);
        checkValue("interpolate", interpolate, k % 4 == 3);
    endtask

    task automatic consumeFrame;
        int t, gap, period;
        time lastRise;
        period = twoClksPerTrellis ? 2 : 4;
        lastRise = 0;
        for (int k = 0; k < pairsPerFrame; k++) begin
            t = 0;
            while (!outReq) begin
                tick;
                t++;
                if (t > 3000) failRun("Timed out waiting for outReq");
            end
            if (k > 0) begin
                gap = int'(($time - lastRise) / 8);
                checkValue("outReqGap", (gap >= period) ? period : gap, period);
            end
            lastRise = $time;
            checkPair(k);
            repeat ($urandom % 5) tick;     // Back-pressure
            checkValue("outReq", outReq, 1'b1);
            checkPair(k);                   // Pair held until ack
            outAck = 1'b1;
            t = 0;
            while (outReq) begin
                tick;
                t++;
                if (t > 20) failRun("outReq was not dropped after outAck");
            end
            repeat ($urandom % 3) tick;
            outAck = 1'b0;
        end
        repeat (30) begin
            tick;
            checkValue("outReq", outReq, 1'b0);     // No extra pair after the frame
        end
    endtask

    initial begin
        int t;
        inReq = 1'b0;
        inSof = 1'b0;
        inReal = '0;
        inImag = '0;
        estimatesDone = 1'b0;
        twoClksPerTrellis = 1'b0;
        mNdx0 = '0;
        mNdx1 = '0;
        outAck = 1'b0;
        void'($urandom(32'h162e45fe));
        t = 0;
        while (reset !== 1'b0) begin
            tick;
            t++;
            if (t > 10) failRun("Reset was never released");
        end
        checkValue("outReq", outReq, 1'b0);
        checkValue("inAck", inAck, 1'b0);
        checkValue("interpolate", interpolate, 1'b0);
        checkValue("startOfTrellis", startOfTrellis, 1'b0);
        for (int f = 0; f < numFrames; f++) begin
            // Offsets from -8 to +5 held steady within a frame
            mNdx0 = offsetT'(int'($urandom % 14) - 8);
            mNdx1 = offsetT'(int'($urandom % 14) - 8);
            if (f < 2) begin
                twoClksPerTrellis = (f == 0);   // Both pacing settings covered
            end else begin
                twoClksPerTrellis = 1'($urandom);
            end
            fork
                produceFrame(f, f == numFrames - 1);
                consumeFrame;
            join
            checkValue("startOfTrellis count", sotCount, f + 1);
            checkValue("inAck count", ackCount, sent);
        end
        sendSample(1'b1, 0, 4);                 // Next frame start closes the last frame
        repeat (40) tick;
        checkValue("inAck count", ackCount, sent);
        checkValue("startOfTrellis count", sotCount, numFrames);
        checkValue("outReq", outReq, 1'b0);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/demodPkg.sv
source/framePkg.sv
source/sampleIngress.sv
source/frameStore.sv
source/trellisFeeder.sv
source/frameAligner.sv
tests/clockGen.sv
tests/frameAlignerTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module frameAlignerTb \
    -o frameAlignerSim

output=$(./obj_dir/frameAlignerSim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
